/* amo_arbiter.f */
logic/amo_pkg.sv
logic/amo_request_latch.sv
logic/amo_grant_buffer.sv
logic/amo_mem_port.sv
logic/amo_arbiter.sv
testbench/amo_arbiter_checker.sv
testbench/amo_arbiter_tb.sv

/* Bender.yml */
package:
  name: amo_arbiter

sources:
  - logic/amo_pkg.sv
  - logic/amo_request_latch.sv
  - logic/amo_grant_buffer.sv
  - logic/amo_mem_port.sv
  - logic/amo_arbiter.sv
  - target: test
    files:
      - testbench/amo_arbiter_checker.sv
      - testbench/amo_arbiter_tb.sv

/* testbench/amo_arbiter_tb.sv */
`timescale 1ns/1ps

module amo_arbiter_tb;

    import amo_pkg::*;

    logic                    clk_i = 1'b0;
    logic                    rst_i;
    core_vec_t               core_strobe;
    core_vec_t               core_is_amo;
    core_vec_t               core_rw;
    core_vec_t               core_ready;
    xlen_t [NUM_CORES-1:0]   core_addr;
    xlen_t [NUM_CORES-1:0]   core_data;
    amo_op_e [NUM_CORES-1:0] core_op;
    xlen_t                   core_rdata;
    logic                    mem_strobe;
    core_id_t                mem_id;
    xlen_t                   mem_addr;
    logic                    mem_rw;
    xlen_t                   mem_wdata;
    amo_op_e                 mem_op;
    logic                    mem_ready;
    xlen_t                   mem_rdata;
    int                      err_count;
    int                      accept_count;
    int                      grant_count;
    int                      tb_errors = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    logic [31:0]             lfsr;
    amo_op_e                 op_table [0:10];

    always #5 clk_i = ~clk_i;

    amo_arbiter amo_arbiter_inst (
        .clk_i (clk_i), .rst_i (rst_i),
        .core_strobe_i (core_strobe), .core_is_amo_i (core_is_amo),
        .core_addr_i (core_addr), .core_rw_i (core_rw), .core_data_i (core_data),
        .core_op_i (core_op), .core_ready_o (core_ready), .core_data_o (core_rdata),
        .mem_strobe_o (mem_strobe), .mem_id_o (mem_id), .mem_addr_o (mem_addr),
        .mem_rw_o (mem_rw), .mem_data_o (mem_wdata), .mem_op_o (mem_op),
        .mem_ready_i (mem_ready), .mem_data_i (mem_rdata)
    );

    amo_arbiter_checker amo_arbiter_checker_inst (
        .clk_i (clk_i), .rst_i (rst_i),
        .core_strobe_i (core_strobe), .core_is_amo_i (core_is_amo),
        .core_addr_i (core_addr), .core_rw_i (core_rw), .core_data_i (core_data),
        .core_op_i (core_op), .core_ready_i (core_ready), .core_rdata_i (core_rdata),
        .mem_strobe_i (mem_strobe), .mem_id_i (mem_id), .mem_addr_i (mem_addr),
        .mem_rw_i (mem_rw), .mem_data_i (mem_wdata), .mem_op_i (mem_op),
        .mem_ready_i (mem_ready), .err_count_o (err_count),
        .accept_count_o (accept_count), .grant_count_o (grant_count)
    );

    // ========================================================================
    // Random bits and helpers
    // ========================================================================

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic reset_dut();
        @(posedge clk_i);
        rst_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
    endtask

    task automatic strobe_core(input int id, input xlen_t addr, input xlen_t data,
                               input logic rw, input amo_op_e op, input logic is_amo);
        @(posedge clk_i);
        core_addr[id]   <= addr;
        core_data[id]   <= data;
        core_rw[id]     <= rw;
        core_op[id]     <= op;
        core_is_amo[id] <= is_amo;
        core_strobe     <= core_vec_t'(1) << id;
        @(posedge clk_i);
        core_strobe     <= '0;
    endtask

    task automatic wait_strobe(output core_id_t id, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!mem_strobe && cycles < 100);
        id = mem_id;
        if (!mem_strobe) begin
            $display("Timed out waiting for a memory strobe");
            tb_errors++;
        end
    endtask

    // Every accepted request has had its response
    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (accept_count != grant_count && cycles < limit);
        if (accept_count != grant_count) begin
            $display("Timed out with %0d requests still outstanding",
                     accept_count - grant_count);
            tb_errors++;
        end
    endtask

    task automatic report(input string name, input int mark);
        int errs;
        errs = tb_errors + err_count - mark;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // Atomic unit with random response delay
    initial begin : atomic_unit
        logic [31:0] d;
        xlen_t       resp;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk_i);
            if (mem_strobe && !rst_i) begin
                resp = amo_arbiter_checker_inst.amo_response(mem_addr, mem_wdata, mem_op);
                take_bits(3, d);
                repeat (d) @(posedge clk_i);
                mem_ready <= 1'b1;
                mem_rdata <= resp;
                @(posedge clk_i);
                mem_ready <= 1'b0;
            end
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        core_id_t    id;
        core_id_t    exp_id;
        core_vec_t   pend;
        core_vec_t   vec;
        core_vec_t   busy;
        core_vec_t   mask;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] o;
        logic        seen;
        int          n;
        int          mark;
        rst_i       = 1'b1;
        core_strobe = '0;
        core_is_amo = '0;
        core_rw     = '0;
        core_addr   = '0;
        core_data   = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            core_op[i] = AMO_ADD;
        end
        lfsr = 32'h2af212d2;
        op_table = '{AMO_ADD, AMO_SWAP, AMO_LR, AMO_SC, AMO_XOR, AMO_OR,
                     AMO_AND, AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        // Idle arbiter gives the strobe in T+3
        mark = tb_errors + err_count;
        strobe_core(2, 32'h0000_1240, 32'h0000_0055, 1'b1, AMO_ADD, 1'b1);
        wait_strobe(id, n);
        if (n != 3) begin
            $display("CHECK FAILED mem_strobe_o latency expected %h got %h", 3, n);
            tb_errors++;
        end
        wait_drained(50);
        report("single strobe", mark);

        mark = tb_errors + err_count;
        strobe_core(0, 32'h0000_2000, 32'h1, 1'b0, AMO_SWAP, 1'b0);
        seen = 1'b0;
        for (int c = 0; c < 20; c++) begin
            @(posedge clk_i);
            seen |= mem_strobe;
        end
        if (seen) begin
            $display("A strobe without the AMO flag reached the memory port");
            tb_errors++;
        end
        report("non-AMO strobe ignored", mark);

        // All cores at once, then cores 1 and 2, then all cores again
        // Middle round leaves the pointer on core 2
        mark = tb_errors + err_count;
        reset_dut();
        exp_id = '0;
        for (int r = 0; r < 3; r++) begin
            mask = (r == 1) ? 4'b0110 : '1;
            @(posedge clk_i);
            for (int i = 0; i < NUM_CORES; i++) begin
                core_addr[i] <= 32'h0000_4000 + 32'(i * 16 + r);
                core_data[i] <= 32'(i + 7);
                core_op[i]   <= op_table[i + r];
            end
            core_is_amo <= '1;
            core_strobe <= mask;
            @(posedge clk_i);
            core_strobe <= '0;
            pend = mask;
            for (int j = 0; |pend; j++) begin
                exp_id = amo_arbiter_checker_inst.next_grant(pend, exp_id);
                wait_strobe(id, n);
                if (id != exp_id || (r == 0 && id != core_id_t'(j + 1))) begin
                    $display("CHECK FAILED mem_id_o expected %h got %h", exp_id, id);
                    tb_errors++;
                end
                pend[exp_id] = 1'b0;
            end
            wait_drained(100);
        end
        report("round robin order", mark);

        mark = tb_errors + err_count;
        for (int k = 0; k < 11; k++) begin
            strobe_core(3, 32'h1357_0000 + 32'(k * 4), 32'h8000_0011 + 32'(k), k[0],
                        op_table[k], 1'b1);
            wait_drained(60);
        end
        report("response routing", mark);

        // Random traffic from all cores
        mark = tb_errors + err_count;
        busy = '0;
        for (int c = 0; c < 300; c++) begin
            @(posedge clk_i);
            busy &= ~core_ready;
            vec = '0;
            for (int i = 0; i < NUM_CORES; i++) begin
                take_bits(2, o);
                if (!busy[i] && o == 3) begin
                    take_bits(32, a);
                    take_bits(32, d);
                    take_bits(4, o);
                    core_addr[i] <= a;
                    core_data[i] <= d;
                    core_rw[i]   <= a[0];
                    core_op[i]   <= op_table[o % 11];
                    vec[i] = 1'b1;
                    busy[i] = 1'b1;
                end
            end
            core_is_amo <= '1;
            core_strobe <= vec;
        end
        @(posedge clk_i);
        core_strobe <= '0;
        wait_drained(1000);
        report("random traffic", mark);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, tb_errors + err_count);
        if (tb_errors + err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* testbench/amo_arbiter_checker.sv */
`timescale 1ns/1ps

module amo_arbiter_checker (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  amo_pkg::core_vec_t                           core_strobe_i,
    input  amo_pkg::core_vec_t                           core_is_amo_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      core_addr_i,
    input  amo_pkg::core_vec_t                           core_rw_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      core_data_i,
    input  amo_pkg::amo_op_e [amo_pkg::NUM_CORES-1:0]    core_op_i,
    input  amo_pkg::core_vec_t                           core_ready_i,
    input  amo_pkg::xlen_t                               core_rdata_i,
    input  logic                                         mem_strobe_i,
    input  amo_pkg::core_id_t                            mem_id_i,
    input  amo_pkg::xlen_t                               mem_addr_i,
    input  logic                                         mem_rw_i,
    input  amo_pkg::xlen_t                               mem_data_i,
    input  amo_pkg::amo_op_e                             mem_op_i,
    input  logic                                         mem_ready_i,
    output int                                           err_count_o,
    output int                                           accept_count_o,
    output int                                           grant_count_o
);

    import amo_pkg::*;

    // Model of the arbiter as seen from its ports
    grant_state_e m_state;
    core_vec_t    m_pending;
    core_id_t     m_prev;
    core_id_t     m_id;
    logic         strobe_due;
    xlen_t        m_addr [NUM_CORES];
    xlen_t        m_data [NUM_CORES];
    logic         m_rw [NUM_CORES];
    amo_op_e      m_op [NUM_CORES];

    // ========================================================================
    // Reference functions
    // ========================================================================

    // Nearest pending core after prev wins, prev itself last
    function automatic core_id_t next_grant(core_vec_t pend, core_id_t prev);
        core_id_t cand;
        core_id_t pick;
        pick = prev;
        for (int k = NUM_CORES; k >= 1; k--) begin
            cand = prev + core_id_t'(k);
            if (pend[cand]) begin
                pick = cand;
            end
        end
        return pick;
    endfunction

    // Old memory word is a pattern of the full address
    function automatic xlen_t amo_response(xlen_t addr, xlen_t data, amo_op_e op);
        xlen_t old;
        old = {addr[15:0] ^ addr[31:16], ~addr[15:0]};
        case (op)
            AMO_ADD:  return old + data;
            AMO_SWAP: return data;
            AMO_SC:   return '0;
            AMO_XOR:  return old ^ data;
            AMO_OR:   return old | data;
            AMO_AND:  return old & data;
            AMO_MIN:  return ($signed(old) < $signed(data)) ? old : data;
            AMO_MAX:  return ($signed(old) > $signed(data)) ? old : data;
            AMO_MINU: return (old < data) ? old : data;
            AMO_MAXU: return (old > data) ? old : data;
            default:  return old;
        endcase
    endfunction

    task automatic compare(input string name, input xlen_t exp, input xlen_t got);
        if (exp !== got) begin
            $display("CHECK FAILED %s expected %h got %h", name, exp, got);
            err_count_o++;
        end
    endtask

    initial begin
        err_count_o    = 0;
        accept_count_o = 0;
        grant_count_o  = 0;
    end

    // ========================================================================
    // Port watcher
    // ========================================================================

    always @(posedge clk_i) begin
        core_vec_t acc;
        core_vec_t exp_ready;
        acc       = core_strobe_i & core_is_amo_i;
        exp_ready = '0;
        if (rst_i) begin
            m_state    = GRANT_IDLE;
            m_pending  = '0;
            m_prev     = '0;
            m_id       = '0;
            strobe_due = 1'b0;
        end else begin
            if (m_state != GRANT_WAIT && mem_strobe_i) begin
                $display("Memory strobe issued while no grant was in progress");
                err_count_o++;
            end
            case (m_state)
                GRANT_IDLE: begin
                    if (|m_pending) begin
                        m_id    = next_grant(m_pending, m_prev);
                        m_state = GRANT_CHOOSE;
                    end
                end
                GRANT_CHOOSE: begin
                    m_prev     = m_id;
                    strobe_due = 1'b1;
                    m_state    = GRANT_WAIT;
                end
                default: begin
                    // First wait cycle carries the strobe and the fields
                    if (strobe_due) begin
                        compare("mem_strobe_o", 1, mem_strobe_i);
                        compare("mem_id_o", m_id, mem_id_i);
                        compare("mem_addr_o", m_addr[m_id], mem_addr_i);
                        compare("mem_data_o", m_data[m_id], mem_data_i);
                        compare("mem_rw_o", m_rw[m_id], mem_rw_i);
                        compare("mem_op_o", m_op[m_id], mem_op_i);
                        strobe_due = 1'b0;
                    end else if (mem_strobe_i) begin
                        $display("Second memory strobe issued before the response");
                        err_count_o++;
                    end
                    if (mem_ready_i) begin
                        exp_ready[m_id] = 1'b1;
                        compare("core_data_o",
                                amo_response(m_addr[m_id], m_data[m_id], m_op[m_id]),
                                core_rdata_i);
                        m_pending[m_id] = 1'b0;
                        grant_count_o++;
                        m_state = GRANT_IDLE;
                    end
                end
            endcase
            compare("core_ready_o", exp_ready, core_ready_i);
            // New requests join after this cycle's choice
            for (int i = 0; i < NUM_CORES; i++) begin
                if (acc[i]) begin
                    if (m_pending[i]) begin
                        $display("Core %0d strobed again while still pending", i);
                        err_count_o++;
                    end
                    m_pending[i] = 1'b1;
                    m_addr[i]    = core_addr_i[i];
                    m_data[i]    = core_data_i[i];
                    m_rw[i]      = core_rw_i[i];
                    m_op[i]      = core_op_i[i];
                    accept_count_o++;
                end
            end
        end
    end

endmodule

/* logic/amo_arbiter.sv */
`timescale 1ns/1ps

module amo_arbiter (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    // Core side
    input  amo_pkg::core_vec_t                           core_strobe_i,
    input  amo_pkg::core_vec_t                           core_is_amo_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      core_addr_i,
    input  amo_pkg::core_vec_t                           core_rw_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      core_data_i,
    input  amo_pkg::amo_op_e [amo_pkg::NUM_CORES-1:0]    core_op_i,
    output amo_pkg::core_vec_t                           core_ready_o,
    output amo_pkg::xlen_t                               core_data_o,
    // Atomic unit side
    output logic                                         mem_strobe_o,
    output amo_pkg::core_id_t                            mem_id_o,
    output amo_pkg::xlen_t                               mem_addr_o,
    output logic                                         mem_rw_o,
    output amo_pkg::xlen_t                               mem_data_o,
    output amo_pkg::amo_op_e                             mem_op_o,
    input  logic                                         mem_ready_i,
    input  amo_pkg::xlen_t                               mem_data_i
);

    import amo_pkg::*;

    // Latch to buffer and port
    core_vec_t                    pending;
    xlen_t   [NUM_CORES-1:0]      req_addr;
    xlen_t   [NUM_CORES-1:0]      req_data;
    core_vec_t                    req_rw;
    amo_op_e [NUM_CORES-1:0]      req_op;
    // Port to buffer
    logic                         select_en;
    logic                         commit;

    // ========================================================================
    // Request capture
    // ========================================================================

    amo_request_latch amo_request_latch_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .core_strobe_i (core_strobe_i),
        .core_is_amo_i (core_is_amo_i),
        .core_addr_i   (core_addr_i),
        .core_data_i   (core_data_i),
        .core_rw_i     (core_rw_i),
        .core_op_i     (core_op_i),
        .core_ready_i  (core_ready_o),
        .pending_o     (pending),
        .req_addr_o    (req_addr),
        .req_data_o    (req_data),
        .req_rw_o      (req_rw),
        .req_op_o      (req_op)
    );

    // ========================================================================
    // Round-robin choice and outgoing request
    // ========================================================================

    // Winner index doubles as the memory request id
    amo_grant_buffer amo_grant_buffer_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .pending_i   (pending),
        .req_addr_i  (req_addr),
        .req_data_i  (req_data),
        .req_rw_i    (req_rw),
        .req_op_i    (req_op),
        .select_en_i (select_en),
        .commit_i    (commit),
        .grant_id_o  (mem_id_o),
        .out_addr_o  (mem_addr_o),
        .out_data_o  (mem_data_o),
        .out_rw_o    (mem_rw_o),
        .out_op_o    (mem_op_o)
    );

    // ========================================================================
    // Grant FSM and response routing
    // ========================================================================

    amo_mem_port amo_mem_port_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .pending_i    (pending),
        .grant_id_i   (mem_id_o),
        .mem_ready_i  (mem_ready_i),
        .mem_data_i   (mem_data_i),
        .select_en_o  (select_en),
        .commit_o     (commit),
        .mem_strobe_o (mem_strobe_o),
        .core_ready_o (core_ready_o),
        .core_data_o  (core_data_o)
    );

endmodule

/* logic/amo_mem_port.sv */
`timescale 1ns/1ps

module amo_mem_port (
    input  logic                clk_i,
    input  logic                rst_i,
    // Arbitration status
    input  amo_pkg::core_vec_t  pending_i,
    input  amo_pkg::core_id_t   grant_id_i,
    // Atomic unit response
    input  logic                mem_ready_i,
    input  amo_pkg::xlen_t      mem_data_i,
    // Control to the grant buffer
    output logic                select_en_o,
    output logic                commit_o,
    // Request strobe to the atomic unit
    output logic                mem_strobe_o,
    // Response to the cores
    output amo_pkg::core_vec_t  core_ready_o,
    output amo_pkg::xlen_t      core_data_o
);

    import amo_pkg::*;

    grant_state_e state;
    grant_state_e state_nxt;

    // ========================================================================
    // Grant FSM
    // ========================================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= GRANT_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            GRANT_IDLE: begin
                // Buffer registers a winner on this same edge
                if (|pending_i) begin
                    state_nxt = GRANT_CHOOSE;
                end
            end
            GRANT_CHOOSE: begin
                // Always one cycle
                state_nxt = GRANT_WAIT;
            end
            GRANT_WAIT: begin
                if (mem_ready_i) begin
                    state_nxt = GRANT_IDLE;
                end
            end
            default: begin
                state_nxt = GRANT_IDLE;
            end
        endcase
    end

    // Winner selection window
    assign select_en_o = (state == GRANT_IDLE);
    // Pointer and outgoing field update
    assign commit_o    = (state == GRANT_CHOOSE);

    // ========================================================================
    // Memory strobe
    // ========================================================================

    // Registered on the edge leaving choose
    // So it is high only in the first wait cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_strobe_o <= 1'b0;
        end else begin
            mem_strobe_o <= (state == GRANT_CHOOSE);
        end
    end

    // ========================================================================
    // Response routing
    // ========================================================================

    // Ready goes only to the granted core and only while waiting
    always_comb begin
        core_ready_o = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            if (state == GRANT_WAIT && grant_id_i == core_id_t'(i)) begin
                core_ready_o[i] = mem_ready_i;
            end
        end
    end

    // One data word shared by all cores
    assign core_data_o = mem_data_i;

    // One strobe per grant
    a_strobe_single: assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_strobe_o |=> !mem_strobe_o
    );

    // At most one core answered at a time
    a_ready_onehot: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $onehot0(core_ready_o)
    );

    // Responses only while a request is outstanding
    a_ready_in_wait: assert property (
        @(posedge clk_i) disable iff (rst_i)
        |core_ready_o |-> state == GRANT_WAIT
    );

endmodule

/* logic/amo_grant_buffer.sv */
`timescale 1ns/1ps

module amo_grant_buffer (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    // Held requests from the latch
    input  amo_pkg::core_vec_t                           pending_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      req_addr_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      req_data_i,
    input  amo_pkg::core_vec_t                           req_rw_i,
    input  amo_pkg::amo_op_e [amo_pkg::NUM_CORES-1:0]    req_op_i,
    // Control from the grant FSM
    input  logic                                         select_en_i,
    input  logic                                         commit_i,
    // Current winner
    output amo_pkg::core_id_t                            grant_id_o,
    // Outgoing request toward the atomic unit
    output amo_pkg::xlen_t                               out_addr_o,
    output amo_pkg::xlen_t                               out_data_o,
    output logic                                         out_rw_o,
    output amo_pkg::amo_op_e                             out_op_o
);

    import amo_pkg::*;

    // Core granted by the last committed choice
    core_id_t prev_grant;
    // Combinational round-robin result
    core_id_t next_winner;

    // ========================================================================
    // Round-robin search
    // ========================================================================

    // Start one past the previous grant and wrap around
    // The previous grant itself is looked at last
    always_comb begin
        core_id_t cand;
        logic     found;
        cand        = prev_grant;
        found       = 1'b0;
        next_winner = grant_id_o;
        for (int k = 1; k <= NUM_CORES; k++) begin
            // Index wraps through the 2 bit type
            cand = prev_grant + core_id_t'(k);
            if (!found && pending_i[cand]) begin
                next_winner = cand;
                found       = 1'b1;
            end
        end
    end

    // ========================================================================
    // Winner and pointer registers
    // ========================================================================

    // Winner only moves in idle cycles with work waiting
    // Stays put through choose and wait so the response goes home
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_id_o <= '0;
        end else if (select_en_i && |pending_i) begin
            grant_id_o <= next_winner;
        end
    end

    // Pointer advances when the FSM leaves choose
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prev_grant <= '0;
        end else if (commit_i) begin
            prev_grant <= grant_id_o;
        end
    end

    // ========================================================================
    // Outgoing request
    // ========================================================================

    // Held stable from the memory strobe until the response
    always_ff @(posedge clk_i) begin
        if (commit_i) begin
            out_addr_o <= req_addr_i[grant_id_o];
            out_data_o <= req_data_i[grant_id_o];
            out_rw_o   <= req_rw_i[grant_id_o];
            out_op_o   <= req_op_i[grant_id_o];
        end
    end

    // Committed winner must still hold a live request
    a_commit_pending: assert property (
        @(posedge clk_i) disable iff (rst_i)
        commit_i |-> pending_i[grant_id_o]
    );

endmodule

/* logic/amo_request_latch.sv */
`timescale 1ns/1ps

module amo_request_latch (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    // Core side request strobes and fields
    input  amo_pkg::core_vec_t                           core_strobe_i,
    input  amo_pkg::core_vec_t                           core_is_amo_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      core_addr_i,
    input  amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      core_data_i,
    input  amo_pkg::core_vec_t                           core_rw_i,
    input  amo_pkg::amo_op_e [amo_pkg::NUM_CORES-1:0]    core_op_i,
    // Response pulse back to the cores
    input  amo_pkg::core_vec_t                           core_ready_i,
    // Held requests
    output amo_pkg::core_vec_t                           pending_o,
    output amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      req_addr_o,
    output amo_pkg::xlen_t [amo_pkg::NUM_CORES-1:0]      req_data_o,
    output amo_pkg::core_vec_t                           req_rw_o,
    output amo_pkg::amo_op_e [amo_pkg::NUM_CORES-1:0]    req_op_o
);

    import amo_pkg::*;

    // Strobes that really belong to the AMO path
    core_vec_t accept;

    assign accept = core_strobe_i & core_is_amo_i;

    // ========================================================================
    // Pending flags
    // ========================================================================

    // Set by an accepted strobe
    // Cleared on the edge after the core's ready pulse
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_o <= '0;
        end else begin
            for (int i = 0; i < NUM_CORES; i++) begin
                if (accept[i]) begin
                    pending_o[i] <= 1'b1;
                end else if (core_ready_i[i]) begin
                    pending_o[i] <= 1'b0;
                end
            end
        end
    end

    // ========================================================================
    // Captured request fields
    // ========================================================================

    // Each core gets its own slot
    // A request made while another is in service stays here
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_CORES; i++) begin
            if (accept[i]) begin
                req_addr_o[i] <= core_addr_i[i];
                req_data_o[i] <= core_data_i[i];
                req_rw_o[i]   <= core_rw_i[i];
                req_op_o[i]   <= core_op_i[i];
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    // Core holds off new AMO strobes up to and including its ready pulse
    for (genvar g = 0; g < NUM_CORES; g++) begin : gen_strobe_chk
        a_no_restrobe: assert property (
            @(posedge clk_i) disable iff (rst_i)
            accept[g] |=> !accept[g] until_with core_ready_i[g]
        );
    end

endmodule

/* logic/amo_pkg.sv */
package amo_pkg;

    // ========================================================================
    // Sizes
    // ========================================================================

    // Requesting cores on the AMO path
    localparam int NUM_CORES = 4;
    // Bits needed to name one core
    localparam int CORE_ID_W = 2;
    // Address and data word width
    localparam int XLEN = 32;
    // RISC-V funct5 field of an AMO instruction
    localparam int AMO_OP_W = 5;

    // ========================================================================
    // Common types
    // ========================================================================

    // One bit per core
    typedef logic [NUM_CORES-1:0] core_vec_t;
    // Core index, wraps naturally at NUM_CORES
    typedef logic [CORE_ID_W-1:0] core_id_t;
    // Address or data word
    typedef logic [XLEN-1:0] xlen_t;

    // RISC-V AMO function codes (funct5)
    typedef enum logic [AMO_OP_W-1:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_LR   = 5'b00010,
        AMO_SC   = 5'b00011,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_op_e;

    // ========================================================================
    // Grant FSM
    // ========================================================================

    // Idle waits for a pending request
    // Choose commits the registered winner
    // Wait holds until the atomic unit answers
    typedef enum logic [1:0] {
        GRANT_IDLE   = 2'd0,
        GRANT_CHOOSE = 2'd1,
        GRANT_WAIT   = 2'd2
    } grant_state_e;

endpackage
